// File: run_sim.sh
#!/bin/sh
# build tb_thumb with Verilator, run it and judge the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module tb_thumb -Mdir "$OBJ" -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_thumb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation passed"
exit 0

// File: src/cam_sampler.sv
`timescale 1ns/10ps

module cam_sampler (
    input  logic                 cmos_pclk,
    input  logic                 rst_n,
    input  logic                 cmos_vsync_i,   // high for the whole frame
    input  logic                 cmos_href_i,    // active pixels of a line
    input  thumb_pkg::pix_t      cmos_db_i,
    input  logic                 wr_ack_i,
    output logic                 wr_req_o,
    output thumb_pkg::row_t      wr_row_o,
    output thumb_pkg::row_idx_t  wr_idx_o,
    output logic                 frame_end_o
);

    logic                 href_d;
    logic                 vsync_d;
    thumb_pkg::cam_x_t    cam_x;
    thumb_pkg::cam_y_t    cam_y;
    logic                 on_grid;
    logic                 in_window;
    logic                 sample_hit;
    logic                 sample_bit;
    logic                 row_done;
    thumb_pkg::row_t      row_sr;       // samples of the current line
    thumb_pkg::row_t      row_next;
    thumb_pkg::row_t      wr_row_q;     // write buffer toward the arbiter
    thumb_pkg::row_idx_t  wr_idx_q;
    logic                 wr_req_q;
    logic                 frame_end_q;

    // ----------------------------------------------------------------------
    // position tracking
    // ----------------------------------------------------------------------

    always_ff @(posedge cmos_pclk or negedge rst_n) begin
        if (!rst_n) begin
            href_d  <= 1'b0;
            vsync_d <= 1'b0;
            cam_x   <= '0;
            cam_y   <= '0;
        end else begin
            href_d  <= cmos_href_i;
            vsync_d <= cmos_vsync_i;

            // pixel index follows href, 0 on first active pixel
            if (!cmos_href_i) begin
                cam_x <= '0;
            end else if (cam_x != '1) begin
                cam_x <= cam_x + 1'b1;   // saturate on overlong lines
            end

            // line index advances at every href fall within the frame
            if (!cmos_vsync_i) begin
                cam_y <= '0;
            end else if (href_d && !cmos_href_i && cam_y != '1) begin
                cam_y <= cam_y + 1'b1;
            end
        end
    end

    // every 16th pixel of every 16th line
    assign on_grid    = (cam_x[thumb_pkg::SAMPLE_SHIFT-1:0] == '0) &&
                        (cam_y[thumb_pkg::SAMPLE_SHIFT-1:0] == '0);
    assign in_window  = (cam_x < thumb_pkg::cam_x_t'(thumb_pkg::WIN_SPAN)) &&
                        (cam_y < thumb_pkg::cam_y_t'(thumb_pkg::WIN_SPAN));
    assign sample_hit = cmos_href_i && on_grid && in_window;
    assign row_done   = sample_hit &&
                        (cam_x == thumb_pkg::cam_x_t'(thumb_pkg::LAST_SAMPLE));

    assign sample_bit = cmos_db_i < thumb_pkg::pix_t'(thumb_pkg::PIX_THRESHOLD);

    // new sample enters at the top and walks down to bit 0
    assign row_next = {sample_bit, row_sr[thumb_pkg::THUMB_DIM-1:1]};

    // ----------------------------------------------------------------------
    // row assembly
    // ----------------------------------------------------------------------

    always_ff @(posedge cmos_pclk) begin
        if (sample_hit) begin
            row_sr <= row_next;
        end
        if (row_done) begin
            wr_row_q <= row_next;   // 28th sample included
            wr_idx_q <= cam_y[thumb_pkg::SAMPLE_SHIFT +: thumb_pkg::ROW_IDX_W];
        end
    end

    // write request and frame end
    always_ff @(posedge cmos_pclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_req_q    <= 1'b0;
            frame_end_q <= 1'b0;
        end else begin
            if (row_done) begin
                wr_req_q <= 1'b1;
            end else if (wr_ack_i) begin
                wr_req_q <= 1'b0;   // release, arbiter drops ack next
            end
            frame_end_q <= vsync_d && !cmos_vsync_i;   // vsync fall
        end
    end

    assign wr_req_o    = wr_req_q;
    assign wr_row_o    = wr_row_q;
    assign wr_idx_o    = wr_idx_q;
    assign frame_end_o = frame_end_q;

    // previous row must be accepted before the next one is ready
    a_row_not_pending: assert property (@(posedge cmos_pclk) disable iff (!rst_n)
        row_done |-> !wr_req_q);

endmodule

// File: src/thumb_arbiter.sv
`timescale 1ns/10ps

module thumb_arbiter (
    input  logic                 cmos_pclk,
    input  logic                 rst_n,
    // sampler side
    input  logic                 wr_req_i,
    input  thumb_pkg::row_t      wr_row_i,
    input  thumb_pkg::row_idx_t  wr_idx_i,
    input  logic                 frame_end_i,
    output logic                 wr_ack_o,
    // streamer side
    input  logic                 rd_req_i,
    input  thumb_pkg::row_idx_t  rd_idx_i,
    input  logic                 stream_busy_i,
    output logic                 rd_ack_o,
    output thumb_pkg::row_t      rd_row_o,
    output logic                 frame_ready_o,
    output logic                 frame_drop_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WR_GRANT,   // write strobe, ack rises at the next edge
        S_WR_ACK,
        S_RD_GRANT,   // read strobe, data and ack at the next edge
        S_RD_ACK
    } arb_state_e;

    arb_state_e  state_q;
    arb_state_e  state_d;
    logic        bank_q;          // back bank select
    logic        frame_ready_q;
    logic        frame_drop_q;
    logic        ram_we;
    logic        ram_re;

    // ----------------------------------------------------------------------
    // grant FSM
    // ----------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (wr_req_i) begin
                    state_d = S_WR_GRANT;   // write wins a tie
                end else if (rd_req_i) begin
                    state_d = S_RD_GRANT;
                end
            end
            S_WR_GRANT: state_d = S_WR_ACK;
            S_WR_ACK:   if (!wr_req_i) state_d = S_IDLE;
            S_RD_GRANT: state_d = S_RD_ACK;
            S_RD_ACK:   if (!rd_req_i) state_d = S_IDLE;
            default:    state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge cmos_pclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= S_IDLE;
            bank_q        <= 1'b0;
            frame_ready_q <= 1'b0;
            frame_drop_q  <= 1'b0;
        end else begin
            state_q       <= state_d;
            frame_ready_q <= 1'b0;
            frame_drop_q  <= 1'b0;
            // swap only when the streamer has let go of the front bank
            if (frame_end_i) begin
                if (!stream_busy_i) begin
                    bank_q        <= ~bank_q;
                    frame_ready_q <= 1'b1;
                end else begin
                    frame_drop_q  <= 1'b1;   // keep banks, lose this frame
                end
            end
        end
    end

    assign ram_we = (state_q == S_WR_GRANT);   // row lands as ack rises
    assign ram_re = (state_q == S_RD_GRANT);

    assign wr_ack_o      = (state_q == S_WR_ACK);
    assign rd_ack_o      = (state_q == S_RD_ACK);
    assign frame_ready_o = frame_ready_q;
    assign frame_drop_o  = frame_drop_q;

    thumb_ram u_ram (
        .cmos_pclk (cmos_pclk),
        .rst_n     (rst_n),
        .we_i      (ram_we),
        .wbank_i   (bank_q),
        .widx_i    (wr_idx_i),
        .wrow_i    (wr_row_i),
        .re_i      (ram_re),
        .ridx_i    (rd_idx_i),
        .rrow_o    (rd_row_o)
    );

    // an ack only answers a live request
    a_wr_ack_req: assert property (@(posedge cmos_pclk) disable iff (!rst_n)
        $rose(wr_ack_o) |-> wr_req_i);
    a_rd_ack_req: assert property (@(posedge cmos_pclk) disable iff (!rst_n)
        $rose(rd_ack_o) |-> rd_req_i);

endmodule

// File: src/thumb_pkg.sv
package thumb_pkg;

    // ----------------------------------------------------------------------
    // thumbnail geometry
    // ----------------------------------------------------------------------

    localparam int THUMB_DIM     = 28;   // samples per side
    localparam int SAMPLE_SHIFT  = 4;    // step of 16 pixels and lines
    localparam int PIX_THRESHOLD = 128;  // dark pixel gives a 1
    localparam int ROW_IDX_W     = 5;    // holds 0..27 and the end value 28
    localparam int NUM_BANKS     = 2;    // front and back thumbnail

    // sampled window span in pixels and lines, 448
    localparam int WIN_SPAN    = THUMB_DIM << SAMPLE_SHIFT;
    // pixel position of the last sample in a row, 432
    localparam int LAST_SAMPLE = (THUMB_DIM - 1) << SAMPLE_SHIFT;

    // sensor side widths
    localparam int CAM_X_W = 10;
    localparam int CAM_Y_W = 9;
    localparam int PIX_W   = 8;

    // ----------------------------------------------------------------------
    // shared types
    // ----------------------------------------------------------------------

    typedef logic [CAM_X_W-1:0]   cam_x_t;    // pixel within line
    typedef logic [CAM_Y_W-1:0]   cam_y_t;    // line within frame
    typedef logic [PIX_W-1:0]     pix_t;      // raw sensor byte

    // one thumbnail row
    // bit k holds the sample at pixel 16*k
    typedef logic [THUMB_DIM-1:0] row_t;

    typedef logic [ROW_IDX_W-1:0] row_idx_t;  // row number

endpackage

// File: src/thumb_ram.sv
`timescale 1ns/10ps

module thumb_ram (
    input  logic                 cmos_pclk,
    input  logic                 rst_n,
    input  logic                 we_i,
    input  logic                 wbank_i,   // back bank, takes the writes
    input  thumb_pkg::row_idx_t  widx_i,
    input  thumb_pkg::row_t      wrow_i,
    input  logic                 re_i,
    input  thumb_pkg::row_idx_t  ridx_i,
    output thumb_pkg::row_t      rrow_o
);

    thumb_pkg::row_t  mem [thumb_pkg::NUM_BANKS][thumb_pkg::THUMB_DIM];
    thumb_pkg::row_t  rrow_q;
    logic             rbank;

    assign rbank = ~wbank_i;   // front bank is the other one

    // write port, cleared thumbnail after reset
    always_ff @(posedge cmos_pclk or negedge rst_n) begin
        if (!rst_n) begin
            mem <= '{default: '0};
        end else if (we_i) begin
            mem[wbank_i][widx_i] <= wrow_i;
        end
    end

    // registered read, one cycle after re_i
    always_ff @(posedge cmos_pclk) begin
        if (re_i) begin
            rrow_q <= mem[rbank][ridx_i];
        end
    end

    assign rrow_o = rrow_q;

    a_widx_range: assert property (@(posedge cmos_pclk) disable iff (!rst_n)
        we_i |-> widx_i < thumb_pkg::row_idx_t'(thumb_pkg::THUMB_DIM));
    a_ridx_range: assert property (@(posedge cmos_pclk) disable iff (!rst_n)
        re_i |-> ridx_i < thumb_pkg::row_idx_t'(thumb_pkg::THUMB_DIM));

endmodule

// File: src/thumb_streamer.sv
`timescale 1ns/10ps

module thumb_streamer (
    input  logic                 cmos_pclk,
    input  logic                 rst_n,
    input  logic                 frame_ready_i,
    output logic                 rd_req_o,
    output thumb_pkg::row_idx_t  rd_idx_o,
    input  logic                 rd_ack_i,
    input  thumb_pkg::row_t      rd_row_i,
    output logic                 stream_busy_o,
    output thumb_pkg::row_t      row_o,
    output thumb_pkg::row_idx_t  row_idx_o,
    output logic                 row_valid_o,
    input  logic                 row_ready_i
);

    logic                 busy_q;
    logic                 rd_req_q;
    thumb_pkg::row_idx_t  rd_idx_q;     // next row to fetch, 28 when done
    logic                 buf_full_q;   // fetched row waiting for output
    thumb_pkg::row_t      buf_q;
    thumb_pkg::row_idx_t  buf_idx_q;
    logic                 valid_q;
    thumb_pkg::row_t      out_q;
    thumb_pkg::row_idx_t  out_idx_q;
    logic                 fetch_left;
    logic                 capture;
    logic                 load;
    logic                 accept;
    logic                 last_accept;

    assign fetch_left  = rd_idx_q < thumb_pkg::row_idx_t'(thumb_pkg::THUMB_DIM);
    assign capture     = rd_req_q && rd_ack_i;                 // rd_row valid now
    assign accept      = valid_q && row_ready_i;
    assign load        = buf_full_q && (!valid_q || row_ready_i);
    assign last_accept = accept &&
                         (out_idx_q == thumb_pkg::row_idx_t'(thumb_pkg::THUMB_DIM - 1));

    // ----------------------------------------------------------------------
    // read sequencing and output handshake
    // ----------------------------------------------------------------------

    always_ff @(posedge cmos_pclk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            rd_req_q   <= 1'b0;
            rd_idx_q   <= '0;
            buf_full_q <= 1'b0;
            valid_q    <= 1'b0;
        end else begin
            if (frame_ready_i && !busy_q) begin
                busy_q   <= 1'b1;
                rd_idx_q <= '0;   // new thumbnail in the front bank
            end else if (last_accept) begin
                busy_q   <= 1'b0;
            end

            // one read in flight, only into an empty buffer
            if (capture) begin
                rd_req_q <= 1'b0;
                rd_idx_q <= rd_idx_q + 1'b1;
            end else if (busy_q && !rd_req_q && !rd_ack_i && !buf_full_q && fetch_left) begin
                rd_req_q <= 1'b1;   // ack must be low again first
            end

            if (capture) begin
                buf_full_q <= 1'b1;
            end else if (load) begin
                buf_full_q <= 1'b0;
            end

            if (load) begin
                valid_q <= 1'b1;
            end else if (accept) begin
                valid_q <= 1'b0;
            end
        end
    end

    // row payload
    always_ff @(posedge cmos_pclk) begin
        if (capture) begin
            buf_q     <= rd_row_i;
            buf_idx_q <= rd_idx_q;
        end
        if (load) begin
            out_q     <= buf_q;
            out_idx_q <= buf_idx_q;
        end
    end

    assign rd_req_o      = rd_req_q;
    assign rd_idx_o      = rd_idx_q;
    assign stream_busy_o = busy_q;
    assign row_o         = out_q;
    assign row_idx_o     = out_idx_q;
    assign row_valid_o   = valid_q;

    // held row stays put under back-pressure
    a_hold_stable: assert property (@(posedge cmos_pclk) disable iff (!rst_n)
        valid_q && !row_ready_i |=> valid_q && $stable(out_q) && $stable(out_idx_q));

endmodule

// File: src/thumb_top.sv
`timescale 1ns/10ps

module thumb_top (
    input  logic                 cmos_pclk,
    input  logic                 rst_n,
    input  logic                 cmos_vsync_i,
    input  logic                 cmos_href_i,
    input  thumb_pkg::pix_t      cmos_db_i,
    input  logic                 row_ready_i,
    output thumb_pkg::row_t      row_o,
    output thumb_pkg::row_idx_t  row_idx_o,
    output logic                 row_valid_o,
    output logic                 frame_drop_o
);

    // ----------------------------------------------------------------------
    // sampler to arbiter
    // ----------------------------------------------------------------------
    logic                 wr_req;
    logic                 wr_ack;
    thumb_pkg::row_t      wr_row;
    thumb_pkg::row_idx_t  wr_idx;
    logic                 frame_end;

    // ----------------------------------------------------------------------
    // streamer to arbiter
    // ----------------------------------------------------------------------
    logic                 rd_req;
    logic                 rd_ack;
    thumb_pkg::row_idx_t  rd_idx;
    thumb_pkg::row_t      rd_row;
    logic                 stream_busy;
    logic                 frame_ready;

    cam_sampler u_sampler (
        .cmos_pclk    (cmos_pclk),
        .rst_n        (rst_n),
        .cmos_vsync_i (cmos_vsync_i),
        .cmos_href_i  (cmos_href_i),
        .cmos_db_i    (cmos_db_i),
        .wr_ack_i     (wr_ack),
        .wr_req_o     (wr_req),
        .wr_row_o     (wr_row),
        .wr_idx_o     (wr_idx),
        .frame_end_o  (frame_end)
    );

    // owns the two-bank memory
    thumb_arbiter u_arbiter (
        .cmos_pclk     (cmos_pclk),
        .rst_n         (rst_n),
        .wr_req_i      (wr_req),
        .wr_row_i      (wr_row),
        .wr_idx_i      (wr_idx),
        .frame_end_i   (frame_end),
        .wr_ack_o      (wr_ack),
        .rd_req_i      (rd_req),
        .rd_idx_i      (rd_idx),
        .stream_busy_i (stream_busy),
        .rd_ack_o      (rd_ack),
        .rd_row_o      (rd_row),
        .frame_ready_o (frame_ready),
        .frame_drop_o  (frame_drop_o)
    );

    thumb_streamer u_streamer (
        .cmos_pclk     (cmos_pclk),
        .rst_n         (rst_n),
        .frame_ready_i (frame_ready),
        .rd_req_o      (rd_req),
        .rd_idx_o      (rd_idx),
        .rd_ack_i      (rd_ack),
        .rd_row_i      (rd_row),
        .stream_busy_o (stream_busy),
        .row_o         (row_o),
        .row_idx_o     (row_idx_o),
        .row_valid_o   (row_valid_o),
        .row_ready_i   (row_ready_i)
    );

endmodule

// File: tb.f
+incdir+test
src/thumb_pkg.sv
src/cam_sampler.sv
src/thumb_ram.sv
src/thumb_arbiter.sv
src/thumb_streamer.sv
src/thumb_top.sv
test/tb_thumb.sv

// File: test/tb_thumb_tasks.svh
// ----------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------

task automatic compare_row(input string name, input thumb_pkg::row_t got,
                           input thumb_pkg::row_t exp);
    if (got !== exp) begin
        row_errors++;
        $display("error at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic compare_idx(input string name, input thumb_pkg::row_idx_t got,
                           input thumb_pkg::row_idx_t exp);
    if (got !== exp) begin
        idx_errors++;
        $display("error at %0t: %s got %0d, expected %0d", $time, name, got, exp);
    end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        bit_errors++;
        $display("error at %0t: %s got %b, expected %b", $time, name, got, exp);
    end
endtask

task automatic check_drops(input int base, input int expected);
    if (drops_seen - base != expected) begin
        other_errors++;
        $display("frame drop count wrong: expected %0d pulses of frame_drop_o, saw %0d",
                 expected, drops_seen - base);
    end
endtask

// ----------------------------------------------------------------------
// stream receiver
// ----------------------------------------------------------------------

// takes rows 0..27, with stall set ready drops for random stretches
task automatic receive_thumbnail(input logic stall);
    int r;
    int hold;
    logic holding;
    thumb_pkg::row_t held_row;
    thumb_pkg::row_idx_t held_idx;
    r        = 0;
    hold     = 0;
    holding  = 1'b0;
    held_row = '0;
    held_idx = '0;
    while (r < thumb_pkg::THUMB_DIM) begin
        @(negedge cmos_pclk);
        if (holding) begin   // row refused last cycle must not move
            compare_bit("row_valid_o", row_valid_o, 1'b1);
            compare_row("row_o", row_o, held_row);
            compare_idx("row_idx_o", row_idx_o, held_idx);
        end
        if (row_valid_o) begin
            if (!holding && stall) begin
                hold = rand_bits(4);   // new row, new stretch
            end
            held_row = row_o;
            held_idx = row_idx_o;
            if (hold > 0) begin
                row_ready_i = 1'b0;
                hold        = hold - 1;
                holding     = 1'b1;
            end else begin
                row_ready_i = 1'b1;   // taken at the next rising edge
                holding     = 1'b0;
                compare_idx("row_idx_o", row_idx_o, thumb_pkg::row_idx_t'(r));
                compare_row("row_o", row_o, exp_rows[thumb_pkg::row_idx_t'(r)]);
                r++;
            end
        end else begin
            row_ready_i = !stall;
            holding     = 1'b0;
        end
    end
endtask

// drives one frame and takes its thumbnail as it streams out
// during vertical blanking
task automatic send_and_receive(input int mode);
    fork
        send_frame(mode);
        begin
            @(negedge cmos_vsync_i);   // model complete at frame end
            case (mode)
                1:       exp_rows = '{default: '1};   // only samples count, all dark
                2:       exp_rows = '{default: '0};
                default: exp_rows = frame_rows;
            endcase
            receive_thumbnail(1'b0);
        end
    join
endtask

// no extra row after index 27
task automatic check_stream_idle();
    repeat (20) begin
        @(negedge cmos_pclk);
        compare_bit("row_valid_o", row_valid_o, 1'b0);
    end
endtask

// ----------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------

task automatic test_reset();
    rst_n = 1'b0;
    repeat (16) begin
        @(negedge cmos_pclk);
        compare_bit("row_valid_o", row_valid_o, 1'b0);
        compare_bit("frame_drop_o", frame_drop_o, 1'b0);
    end
    rst_n = 1'b1;
    repeat (8) begin
        @(negedge cmos_pclk);
        compare_bit("row_valid_o", row_valid_o, 1'b0);
        compare_bit("frame_drop_o", frame_drop_o, 1'b0);
    end
endtask

task automatic test_random_thumbnail();
    int base;
    base = drops_seen;
    row_ready_i = 1'b1;
    send_and_receive(0);
    check_stream_idle();
    check_drops(base, 0);
endtask

task automatic test_sampled_pixels();
    int base;
    base = drops_seen;
    send_and_receive(1);
    check_stream_idle();
    send_and_receive(2);
    check_stream_idle();
    check_drops(base, 0);
endtask

task automatic test_back_pressure();
    int base;
    base = drops_seen;
    row_ready_i = 1'b0;
    send_frame(0);
    exp_rows = frame_rows;
    receive_thumbnail(1'b1);
    check_stream_idle();
    check_drops(base, 0);
endtask

task automatic test_frame_drop();
    int base;
    base = drops_seen;
    row_ready_i = 1'b0;
    send_frame(0);                 // swapped in, streamer stalls on row 0
    exp_rows = frame_rows;
    send_frame(0);                 // ends while busy, dropped
    check_drops(base, 1);
    @(negedge cmos_pclk);
    compare_bit("row_valid_o", row_valid_o, 1'b1);
    compare_idx("row_idx_o", row_idx_o, '0);
    receive_thumbnail(1'b0);       // first thumbnail still intact
    check_stream_idle();
    send_and_receive(0);           // third frame swaps in
    check_stream_idle();
    check_drops(base, 1);
endtask

// File: test/tb_thumb.sv
`timescale 1ns/10ps

module tb_thumb;

    // ----------------------------------------------------------------------
    // frame geometry and run length
    // ----------------------------------------------------------------------

    localparam int LINES   = 440;   // lines per frame
    localparam int PIXELS  = 460;   // href-high pixels per line
    localparam int GAP     = 20;    // blanking after each line
    localparam int VS_GAP  = 40;    // vsync low after the frame
    localparam int STEP    = 1 << thumb_pkg::SAMPLE_SHIFT;
    localparam int FRAME_CYCLES = LINES * (PIXELS + GAP) + VS_GAP + 1;
    // seven frames in all plus streaming and stalls, about 1.5M cycles
    localparam int TIMEOUT_CYCLES = 7 * FRAME_CYCLES + 20000;

    logic                 cmos_pclk;
    logic                 rst_n;
    logic                 cmos_vsync_i;
    logic                 cmos_href_i;
    thumb_pkg::pix_t      cmos_db_i;
    logic                 row_ready_i;
    thumb_pkg::row_t      row_o;
    thumb_pkg::row_idx_t  row_idx_o;
    logic                 row_valid_o;
    logic                 frame_drop_o;

    logic [15:0]          lfsr_q = 16'd21467;
    thumb_pkg::row_t      frame_rows [thumb_pkg::THUMB_DIM];   // model of the last sent frame
    thumb_pkg::row_t      exp_rows   [thumb_pkg::THUMB_DIM];   // what the next stream must show
    int                   row_errors;
    int                   idx_errors;
    int                   bit_errors;
    int                   other_errors;
    int                   drops_seen;
    int                   cycle_count;
    int                   total;

    always #20 cmos_pclk = ~cmos_pclk;   // 40 ns pixel clock

    thumb_top DUT (
        .cmos_pclk    (cmos_pclk),
        .rst_n        (rst_n),
        .cmos_vsync_i (cmos_vsync_i),
        .cmos_href_i  (cmos_href_i),
        .cmos_db_i    (cmos_db_i),
        .row_ready_i  (row_ready_i),
        .row_o        (row_o),
        .row_idx_o    (row_idx_o),
        .row_valid_o  (row_valid_o),
        .frame_drop_o (frame_drop_o)
    );

    // ----------------------------------------------------------------------
    // random source, x^16 + x^14 + x^13 + x^11
    // ----------------------------------------------------------------------

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_bit());   // one step per bit
        end
        return v;
    endfunction

    function automatic thumb_pkg::pix_t rand_byte();
        return thumb_pkg::pix_t'(rand_bits(8));
    endfunction

    // ----------------------------------------------------------------------
    // frame driver
    // ----------------------------------------------------------------------

    // mode 0 random, 1 dark samples on bright ground, 2 the reverse
    task automatic send_frame(input int mode);
        int x;
        int y;
        logic sampled;
        thumb_pkg::pix_t pix;
        frame_rows = '{default: '0};
        @(negedge cmos_pclk);
        cmos_vsync_i = 1'b1;
        for (y = 0; y < LINES; y++) begin
            for (x = 0; x < PIXELS; x++) begin
                sampled = (x % STEP == 0) && (y % STEP == 0) &&
                          (x < thumb_pkg::WIN_SPAN) && (y < thumb_pkg::WIN_SPAN);
                case (mode)
                    1:       pix = sampled ? (rand_byte() & 8'h7f) : (rand_byte() | 8'h80);
                    2:       pix = sampled ? (rand_byte() | 8'h80) : (rand_byte() & 8'h7f);
                    default: pix = rand_byte();
                endcase
                if (sampled) begin
                    // dark pixel gives a 1, bit k of row r is pixel (16k, 16r)
                    frame_rows[thumb_pkg::row_idx_t'(y / STEP)][thumb_pkg::row_idx_t'(x / STEP)]
                        = int'(pix) < thumb_pkg::PIX_THRESHOLD;
                end
                cmos_href_i = 1'b1;
                cmos_db_i   = pix;
                @(negedge cmos_pclk);
            end
            cmos_href_i = 1'b0;
            cmos_db_i   = '0;
            repeat (GAP) @(negedge cmos_pclk);   // horizontal blanking
        end
        cmos_vsync_i = 1'b0;   // frame end, swap or drop follows
        repeat (VS_GAP) @(negedge cmos_pclk);
    endtask

    `include "tb_thumb_tasks.svh"

    // frame_drop_o is a one-cycle pulse, the falling edge sees it once
    always @(negedge cmos_pclk) begin
        if (rst_n && frame_drop_o) begin
            drops_seen <= drops_seen + 1;
        end
    end

    always @(posedge cmos_pclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        cmos_pclk    = 1'b0;
        rst_n        = 1'b0;
        cmos_vsync_i = 1'b0;
        cmos_href_i  = 1'b0;
        cmos_db_i    = '0;
        row_ready_i  = 1'b0;
        row_errors   = 0;
        idx_errors   = 0;
        bit_errors   = 0;
        other_errors = 0;

        test_reset();
        test_random_thumbnail();
        test_sampled_pixels();
        test_back_pressure();
        test_frame_drop();

        total = row_errors + idx_errors + bit_errors + other_errors;
        $display("error counts: row %0d, index %0d, flag %0d, other %0d",
                 row_errors, idx_errors, bit_errors, other_errors);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        drops_seen  = 0;
        cycle_count = 0;
    end

endmodule
